//--- build.f
common/rv_isa_pkg.sv
common/pipe_ctrl_pkg.sv
common/dest_tag_if.sv
hazard/load_use_detector.sv
hazard/dest_tag_pipe.sv
source/reg_file.sv
source/operand_forward.sv
source/operand_stage_top.sv
test/tb_clock_gen.sv
test/operand_stage_tb.sv

//--- common/dest_tag_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dest_tag_if;
    import rv_isa_pkg::*;

    logic                  ex_wr;
    logic [reg_addr_w-1:0] ex_rd;
    logic                  ex_load; // Instruction in EX is a load
    logic                  mem_wr;
    logic [reg_addr_w-1:0] mem_rd;
    logic                  wb_wr;
    logic [reg_addr_w-1:0] wb_rd;

    modport pipe (
        output ex_wr, ex_rd, ex_load,
        output mem_wr, mem_rd,
        output wb_wr, wb_rd
    );

    modport hazard (
        input ex_wr, ex_rd, ex_load
    );

    modport fwd (
        input ex_wr, ex_rd, ex_load,
        input mem_wr, mem_rd,
        input wb_wr, wb_rd
    );

endinterface

`default_nettype wire

//--- common/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    // IF, ID, EX, MEM, WB
    localparam int pipe_stages = 5;

    // Stages behind decode that carry a destination tag
    localparam int tag_stages = pipe_stages - 2;

    typedef enum logic [1:0] {
        src_regfile = 2'd0,
        src_ex      = 2'd1,
        src_mem     = 2'd2,
        src_wb      = 2'd3
    } opnd_src_e;

endpackage

`default_nettype wire

//--- common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen_default = 64;
    localparam int reg_addr_w = 5;

    typedef enum logic [2:0] {
        op_alu_reg = 3'd0, // rs1, rs2 -> rd
        op_alu_imm = 3'd1, // rs1 -> rd
        op_load    = 3'd2, // Result is ready only in MEM
        op_store   = 3'd3, // rs1, rs2, no destination
        op_branch  = 3'd4  // rs1, rs2, no destination
    } op_class_e;

    function automatic logic reads_rs1(input op_class_e op);
        return op inside {op_alu_reg, op_alu_imm, op_load, op_store, op_branch};
    endfunction

    function automatic logic reads_rs2(input op_class_e op);
        return op inside {op_alu_reg, op_store, op_branch};
    endfunction

    function automatic logic writes_rd(input op_class_e op);
        return op inside {op_alu_reg, op_alu_imm, op_load};
    endfunction

endpackage

`default_nettype wire

//--- hazard/dest_tag_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module dest_tag_pipe (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              id_valid,
    input  rv_isa_pkg::op_class_e             id_op,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] id_rd,
    input  logic                              stall,
    dest_tag_if.pipe                          tags
);
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic                  issue;
    logic                  id_writes;
    logic                  id_is_load;

    // Index 0 is EX, the last index is WB
    logic                  wr_q [tag_stages];
    logic [reg_addr_w-1:0] rd_q [tag_stages];
    logic                  ex_load_q;

    assign issue      = id_valid && !stall;
    assign id_writes  = writes_rd(id_op) && (id_rd != '0); // Writes to x0 are dropped here
    assign id_is_load = (id_op == op_load);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < tag_stages; i++) begin
                wr_q[i] <= 1'b0;
                rd_q[i] <= '0;
            end
            ex_load_q <= 1'b0;
        end else begin
            // A stalled or empty decode slot enters EX as a bubble
            wr_q[0]   <= issue && id_writes;
            rd_q[0]   <= (issue && id_writes) ? id_rd : '0;
            ex_load_q <= issue && id_is_load;
            for (int i = 1; i < tag_stages; i++) begin
                wr_q[i] <= wr_q[i-1];
                rd_q[i] <= rd_q[i-1];
            end
        end
    end

    assign tags.ex_wr   = wr_q[0];
    assign tags.ex_rd   = rd_q[0];
    assign tags.ex_load = ex_load_q;
    assign tags.mem_wr  = wr_q[1];
    assign tags.mem_rd  = rd_q[1];
    assign tags.wb_wr   = wr_q[tag_stages-1];
    assign tags.wb_rd   = rd_q[tag_stages-1];

    a_no_x0_writer: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(tags.ex_wr  && (tags.ex_rd  == '0)) &&
        !(tags.mem_wr && (tags.mem_rd == '0)) &&
        !(tags.wb_wr  && (tags.wb_rd  == '0))
    ) else $error("Fail %0t: write flag set with destination x0", $time);

endmodule

`default_nettype wire

//--- hazard/load_use_detector.sv
`timescale 1ns/10ps
`default_nettype none

module load_use_detector (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              id_valid,
    input  rv_isa_pkg::op_class_e             id_op,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] id_rs2,
    dest_tag_if.hazard                        tags,
    output logic                              stall
);
    import rv_isa_pkg::*;

    logic use_rs1;
    logic use_rs2;
    logic hit_rs1;
    logic hit_rs2;
    logic load_in_ex;
    logic stall_q;

    // x0 is never a real dependency
    assign use_rs1 = reads_rs1(id_op) && (id_rs1 != '0);
    assign use_rs2 = reads_rs2(id_op) && (id_rs2 != '0);

    assign load_in_ex = tags.ex_wr && tags.ex_load;

    assign hit_rs1 = use_rs1 && (id_rs1 == tags.ex_rd);
    assign hit_rs2 = use_rs2 && (id_rs2 == tags.ex_rd);

    // Load data exists only in MEM, so decode waits one cycle
    assign stall = id_valid && load_in_ex && (hit_rs1 || hit_rs2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall;
        end
    end

    // The stall inserts a bubble in EX, which must clear the hazard next cycle
    a_stall_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_q |-> !stall
    ) else $error("Fail %0t: stall high for two cycles in a row", $time);

    a_stall_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |-> id_valid
    ) else $error("Fail %0t: stall without a valid decode instruction", $time);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the operand stage testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
sim_bin=operand_stage_sim
log_file=sim.log

verilator --binary --timing --assert \
    -f build.f \
    --top-module operand_stage_tb \
    -Mdir "${obj_dir}" \
    -o "${sim_bin}"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./${obj_dir}/${sim_bin}" > "${log_file}" 2>&1
sim_status=$?
cat "${log_file}"
if [ ${sim_status} -ne 0 ]; then
    echo "Simulation exited with status ${sim_status}"
    exit 1
fi

if grep -q "^RESULT: PASS$" "${log_file}"; then
    exit 0
fi

echo "Pass message not found in ${log_file}"
exit 1

//--- source/operand_forward.sv
`timescale 1ns/10ps
`default_nettype none

module operand_forward #(
    parameter int xlen = rv_isa_pkg::xlen_default
) (
    input  rv_isa_pkg::op_class_e             id_op,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] id_rs2,
    dest_tag_if.fwd                           tags,
    input  logic [xlen-1:0]                   rf_rdata1,
    input  logic [xlen-1:0]                   rf_rdata2,
    input  logic [xlen-1:0]                   ex_result,
    input  logic [xlen-1:0]                   mem_result,
    input  logic [xlen-1:0]                   wb_result,
    output logic [xlen-1:0]                   rs1_val,
    output logic [xlen-1:0]                   rs2_val
);
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    opnd_src_e src1;
    opnd_src_e src2;

    // Youngest writer wins; the *_wr flags already exclude x0
    function automatic opnd_src_e pick_src(
        input logic [reg_addr_w-1:0] rs,
        input logic                  ex_wr,
        input logic [reg_addr_w-1:0] ex_rd,
        input logic                  mem_wr,
        input logic [reg_addr_w-1:0] mem_rd,
        input logic                  wb_wr,
        input logic [reg_addr_w-1:0] wb_rd
    );
        if (ex_wr && (ex_rd == rs)) return src_ex;
        if (mem_wr && (mem_rd == rs)) return src_mem;
        if (wb_wr && (wb_rd == rs)) return src_wb;
        return src_regfile;
    endfunction

    function automatic logic [xlen-1:0] src_value(
        input opnd_src_e       src,
        input logic [xlen-1:0] rf_val
    );
        case (src)
            src_ex:  return ex_result;  // Decode stalls while this is a load
            src_mem: return mem_result;
            src_wb:  return wb_result;
            default: return rf_val;
        endcase
    endfunction

    assign src1 = pick_src(id_rs1, tags.ex_wr, tags.ex_rd, tags.mem_wr, tags.mem_rd,
                           tags.wb_wr, tags.wb_rd);
    assign src2 = pick_src(id_rs2, tags.ex_wr, tags.ex_rd, tags.mem_wr, tags.mem_rd,
                           tags.wb_wr, tags.wb_rd);

    always_comb begin
        rs1_val = reads_rs1(id_op) ? src_value(src1, rf_rdata1) : '0;
        rs2_val = reads_rs2(id_op) ? src_value(src2, rf_rdata2) : '0;
    end

endmodule

`default_nettype wire

//--- source/operand_stage_top.sv
`timescale 1ns/10ps
`default_nettype none

module operand_stage_top #(
    parameter int xlen = rv_isa_pkg::xlen_default
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              id_valid,
    input  rv_isa_pkg::op_class_e             id_op,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] id_rd,
    input  logic [xlen-1:0]                   ex_result,
    input  logic [xlen-1:0]                   mem_result,
    input  logic [xlen-1:0]                   wb_result,
    output logic [xlen-1:0]                   rs1_val,
    output logic [xlen-1:0]                   rs2_val,
    output logic                              stall
);

    logic [xlen-1:0] rf_rdata1;
    logic [xlen-1:0] rf_rdata2;

    dest_tag_if tags_if ();

    dest_tag_pipe u_dest_tag_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_valid (id_valid),
        .id_op    (id_op),
        .id_rd    (id_rd),
        .stall    (stall),
        .tags     (tags_if.pipe)
    );

    load_use_detector u_load_use_detector (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_valid (id_valid),
        .id_op    (id_op),
        .id_rs1   (id_rs1),
        .id_rs2   (id_rs2),
        .tags     (tags_if.hazard),
        .stall    (stall)
    );

    // Write port is driven by the instruction leaving WB
    reg_file #(
        .xlen (xlen)
    ) u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (id_rs1),
        .raddr2 (id_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (tags_if.wb_wr),
        .waddr  (tags_if.wb_rd),
        .wdata  (wb_result)
    );

    operand_forward #(
        .xlen (xlen)
    ) u_operand_forward (
        .id_op      (id_op),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .tags       (tags_if.fwd),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val)
    );

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file #(
    parameter int xlen = rv_isa_pkg::xlen_default
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]                   rdata1,
    output logic [xlen-1:0]                   rdata2,
    input  logic                              we,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]                   wdata
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Reads see the old value in the write cycle, when WB forwarding supplies the operand
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

//--- test/operand_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module operand_stage_tb;
    import rv_isa_pkg::*;

    localparam int xlen       = xlen_default;
    localparam int num_random = 400;
    // About 40 directed cycles and at most two cycles per random instruction, with margin
    localparam int max_cycles = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  id_valid;
    op_class_e             id_op;
    logic [reg_addr_w-1:0] id_rs1;
    logic [reg_addr_w-1:0] id_rs2;
    logic [reg_addr_w-1:0] id_rd;
    logic [xlen-1:0]       ex_result;
    logic [xlen-1:0]       mem_result;
    logic [xlen-1:0]       wb_result;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic                  stall;

    // Shadow copy of the destination tags and the register file
    logic                  sh_ex_wr;
    logic [reg_addr_w-1:0] sh_ex_rd;
    logic                  sh_ex_load;
    logic                  sh_mem_wr;
    logic [reg_addr_w-1:0] sh_mem_rd;
    logic                  sh_wb_wr;
    logic [reg_addr_w-1:0] sh_wb_rd;
    logic [xlen-1:0]       sh_regs [32];
    logic                  exp_stall;
    logic [xlen-1:0]       exp_rs1;
    logic [xlen-1:0]       exp_rs2;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          stall_seen = 0;
    int          stall_errs = 0;
    int          rs1_errs = 0;
    int          rs2_errs = 0;
    int          other_errs = 0;

    tb_clock_gen #(
        .period_ns    (40),
        .reset_cycles (2)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    operand_stage_top #(
        .xlen (xlen)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (id_valid),
        .id_op      (id_op),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .id_rd      (id_rd),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .stall      (stall)
    );

    function automatic logic class_reads_rs1(input op_class_e op);
        return (op == op_alu_reg) || (op == op_alu_imm) || (op == op_load) ||
               (op == op_store) || (op == op_branch);
    endfunction

    function automatic logic class_reads_rs2(input op_class_e op);
        return (op == op_alu_reg) || (op == op_store) || (op == op_branch);
    endfunction

    function automatic logic class_writes_rd(input op_class_e op);
        return (op == op_alu_reg) || (op == op_alu_imm) || (op == op_load);
    endfunction

    // Youngest writer first, then the shadow register file
    function automatic logic [xlen-1:0] model_operand(input logic used,
                                                      input logic [reg_addr_w-1:0] rs);
        if (!used || (rs == '0)) return '0;
        if (sh_ex_wr && (sh_ex_rd == rs)) return ex_result;
        if (sh_mem_wr && (sh_mem_rd == rs)) return mem_result;
        if (sh_wb_wr && (sh_wb_rd == rs)) return wb_result;
        return sh_regs[rs];
    endfunction

    always_comb begin
        exp_rs1 = model_operand(class_reads_rs1(id_op), id_rs1);
        exp_rs2 = model_operand(class_reads_rs2(id_op), id_rs2);
        exp_stall = id_valid && sh_ex_wr && sh_ex_load &&
            ((class_reads_rs1(id_op) && (id_rs1 != '0) && (id_rs1 == sh_ex_rd)) ||
             (class_reads_rs2(id_op) && (id_rs2 != '0) && (id_rs2 == sh_ex_rd)));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sh_ex_wr   <= 1'b0;
            sh_ex_rd   <= '0;
            sh_ex_load <= 1'b0;
            sh_mem_wr  <= 1'b0;
            sh_mem_rd  <= '0;
            sh_wb_wr   <= 1'b0;
            sh_wb_rd   <= '0;
            for (int i = 0; i < 32; i++) begin
                sh_regs[i] <= '0;
            end
        end else begin
            sh_ex_wr   <= id_valid && !exp_stall && class_writes_rd(id_op) && (id_rd != '0);
            sh_ex_rd   <= id_rd;
            sh_ex_load <= id_valid && !exp_stall && (id_op == op_load);
            sh_mem_wr  <= sh_ex_wr;
            sh_mem_rd  <= sh_ex_rd;
            sh_wb_wr   <= sh_mem_wr;
            sh_wb_rd   <= sh_mem_rd;
            if (sh_wb_wr) begin
                sh_regs[sh_wb_rd] <= wb_result;
            end
        end
    end

    a_stall_matches: assert property (@(posedge clk) disable iff (!rst_n) stall == exp_stall)
    else begin
        stall_errs++;
        $display("Fail %0t: stall is %0b, expected %0b", $time, $sampled(stall),
                 $sampled(exp_stall));
    end

    a_stall_once: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
    else begin
        stall_errs++;
        $display("Fail %0t: stall stayed high for a second cycle", $time);
    end

    a_rs1_matches: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_stall |-> rs1_val == exp_rs1)
    else begin
        rs1_errs++;
        $display("Fail %0t: rs1_val is %h, expected %h", $time, $sampled(rs1_val),
                 $sampled(exp_rs1));
    end

    a_rs2_matches: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_stall |-> rs2_val == exp_rs2)
    else begin
        rs2_errs++;
        $display("Fail %0t: rs2_val is %h, expected %h", $time, $sampled(rs2_val),
                 $sampled(exp_rs2));
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (rst_n && exp_stall) begin
            stall_seen <= stall_seen + 1;
        end
        if (cycle_count >= max_cycles) begin
            $display("The run timed out after %0d cycles", max_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [xlen-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[xlen-2:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_results();
        logic [xlen-1:0] r_ex;
        logic [xlen-1:0] r_mem;
        logic [xlen-1:0] r_wb;
        draw_bits(xlen, r_ex);
        draw_bits(xlen, r_mem);
        draw_bits(xlen, r_wb);
        ex_result  <= r_ex;
        mem_result <= r_mem;
        wb_result  <= r_wb;
    endtask

    task automatic issue(input logic valid, input op_class_e op, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [4:0] rd);
        @(posedge clk);
        id_valid <= valid;
        id_op    <= op;
        id_rs1   <= rs1;
        id_rs2   <= rs2;
        id_rd    <= rd;
        drive_results();
        @(negedge clk);
        while (stall) begin // Decode holds its instruction
            @(posedge clk);
            drive_results();
            @(negedge clk);
        end
    endtask

    task automatic bubbles(input int n);
        repeat (n) issue(1'b0, op_alu_reg, 5'd0, 5'd0, 5'd0);
    endtask

    task automatic random_instr();
        logic [xlen-1:0] bits;
        logic            valid;
        logic [2:0]      opv;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        draw_bits(3, bits);
        valid = (bits[2:0] != 3'd0);
        draw_bits(3, bits);
        opv = bits[2:0];
        if (opv > 3'd4) opv = opv - 3'd4;
        // Registers x0 to x7 only, so that hazards are frequent
        draw_bits(3, bits);
        rs1 = {2'b00, bits[2:0]};
        draw_bits(3, bits);
        rs2 = {2'b00, bits[2:0]};
        draw_bits(3, bits);
        rd = {2'b00, bits[2:0]};
        issue(valid, op_class_e'(opv), rs1, rs2, rd);
    endtask

    initial begin
        lfsr_state = 32'h0a71_2286;
        id_valid   = 1'b0;
        id_op      = op_alu_reg;
        id_rs1     = '0;
        id_rs2     = '0;
        id_rd      = '0;
        ex_result  = '0;
        mem_result = '0;
        wb_result  = '0;
        @(posedge rst_n);

        issue(1'b1, op_store, 5'd1, 5'd2, 5'd0);
        issue(1'b1, op_branch, 5'd31, 5'd17, 5'd0);

        // Load into x0, then reads of x0 and of an unused rs2
        issue(1'b1, op_load, 5'd0, 5'd0, 5'd0);
        issue(1'b1, op_alu_reg, 5'd0, 5'd0, 5'd3);
        issue(1'b1, op_load, 5'd1, 5'd0, 5'd5);
        issue(1'b1, op_alu_imm, 5'd1, 5'd5, 5'd6);

        // Load-use on rs1 and on rs2
        issue(1'b1, op_load, 5'd2, 5'd0, 5'd3);
        issue(1'b1, op_alu_reg, 5'd3, 5'd1, 5'd4);
        issue(1'b1, op_load, 5'd2, 5'd0, 5'd4);
        issue(1'b1, op_store, 5'd1, 5'd4, 5'd0);

        // x7 written by several instructions in flight
        issue(1'b1, op_alu_reg, 5'd1, 5'd2, 5'd7);
        issue(1'b1, op_alu_imm, 5'd7, 5'd0, 5'd7);
        issue(1'b1, op_alu_reg, 5'd7, 5'd7, 5'd7);
        issue(1'b1, op_branch, 5'd7, 5'd7, 5'd0);
        issue(1'b1, op_alu_reg, 5'd1, 5'd2, 5'd7);
        issue(1'b1, op_alu_imm, 5'd3, 5'd0, 5'd7);
        bubbles(1);
        issue(1'b1, op_store, 5'd7, 5'd7, 5'd0);
        issue(1'b1, op_branch, 5'd7, 5'd1, 5'd0);
        bubbles(3);
        issue(1'b1, op_alu_reg, 5'd7, 5'd6, 5'd0);

        // Non-load producer forwards from EX
        issue(1'b1, op_alu_imm, 5'd1, 5'd0, 5'd2);
        issue(1'b1, op_branch, 5'd2, 5'd2, 5'd0);
        bubbles(4);

        repeat (num_random) random_instr();
        bubbles(4);

        if (stall_seen == 0) begin
            other_errs++;
            $display("The stimulus never reached a load-use stall");
        end
        $display("Errors: stall %0d, rs1 %0d, rs2 %0d, other %0d", stall_errs, rs1_errs,
                 rs2_errs, other_errs);
        if (stall_errs + rs1_errs + rs2_errs + other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1; // Released on a rising edge
    end

endmodule

`default_nettype wire
